//--- lc3b_core.f
+incdir+sim
src/lc3b_pkg.sv
src/lc3b_stage_if.sv
src/lc3b_result_if.sv
src/lc3b_regfile.sv
src/lc3b_decode.sv
src/lc3b_execute.sv
src/lc3b_result.sv
src/lc3b_core.sv
sim/lc3b_core_tb.sv

//--- sim/lc3b_model.svh
`ifndef LC3B_MODEL_SVH
`define LC3B_MODEL_SVH

// Architectural state as the instruction stream sees it
logic [15:0] model_regs [8];
logic [2:0]  model_cc;

// Expected writebacks in order, packed as {dest, data, cc}
logic [21:0] expect_q [$];

function automatic logic [2:0] cc_for(input logic [15:0] value);
    if (value[15]) begin
        return 3'b100;
    end else if (value == 16'h0000) begin
        return 3'b010;
    end
    return 3'b001;
endfunction

task automatic reset_model();
    foreach (model_regs[i]) begin
        model_regs[i] = 16'h0000;
    end
    model_cc = 3'b010;
    expect_q.delete();
endtask

task automatic execute_instr(input logic [15:0] instr);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] value;
    logic        writes;
    a = model_regs[instr[8:6]];
    // Bit 5 picks the sign-extended imm5 over SR2
    b = instr[5] ? {{11{instr[4]}}, instr[4:0]} : model_regs[instr[2:0]];
    writes = 1'b1;
    case (instr[15:12])
        4'b0001: value = a + b;
        4'b0101: value = a & b;
        4'b1001: value = ~a;
        4'b1101: begin
            value = a;
            // One bit per step, bit 4 means right, bit 5 means sign fill
            for (int i = 0; i < instr[3:0]; i++) begin
                if (!instr[4]) begin
                    value = {value[14:0], 1'b0};
                end else begin
                    value = {instr[5] & value[15], value[15:1]};
                end
            end
        end
        default: writes = 1'b0;
    endcase
    if (writes) begin
        model_regs[instr[11:9]] = value;
        model_cc = cc_for(value);
        expect_q.push_back({instr[11:9], value, model_cc});
    end
endtask

`endif

//--- sim/lc3b_core_tb.sv
`timescale 1ns/1ns

module lc3b_core_tb;

    localparam int WAIT_LIMIT = 200;

    logic        clk = 1'b0;
    logic        i_rst_n;
    logic        i_instr_valid;
    logic [15:0] i_instr;
    logic        o_instr_ready;
    logic        o_wb_valid;
    logic [2:0]  o_wb_dest;
    logic [15:0] o_wb_data;
    logic [2:0]  o_cc;
    logic        i_wb_ready;

    logic [31:0] instr_rng = 32'd68905;
    logic [31:0] stall_rng = 32'd68905 ^ 32'h5bd1e995;
    int          stall_pct = 0;
    logic        dep_mode = 1'b0;
    int          error_count = 0;
    int          timeout_count = 0;
    int          wb_count = 0;

    `include "lc3b_model.svh"

    lc3b_core i_dut (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb_dest     (o_wb_dest),
        .o_wb_data     (o_wb_data),
        .o_cc          (o_cc),
        .i_wb_ready    (i_wb_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts (%0d writebacks checked)",
                 error_count, timeout_count, wb_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        timeout_count++;
        finish_run();
    endtask

    // Weighted toward the kept opcodes, dep_mode keeps only R0 and R1 live
    function automatic logic [15:0] random_instr();
        logic [31:0] r;
        logic [2:0]  dr;
        logic [2:0]  sr1;
        logic [2:0]  sr2;
        logic [3:0]  op;
        instr_rng = xorshift(instr_rng);
        r = instr_rng;
        dr = dep_mode ? {2'b00, r[4]} : r[6:4];
        sr1 = dep_mode ? {2'b00, r[7]} : r[9:7];
        sr2 = dep_mode ? {2'b00, r[10]} : r[12:10];
        case (r[3:0])
            0, 1, 2, 3: return {4'b0001, dr, sr1, r[13], r[13] ? r[18:14] : {2'b00, sr2}};
            4, 5, 6:    return {4'b0101, dr, sr1, r[13], r[13] ? r[18:14] : {2'b00, sr2}};
            7, 8:       return {4'b1001, dr, sr1, 6'b111111};
            9, 10, 11:  return {4'b1101, dr, sr1, r[20:19], r[24:21]};
            default: begin
                op = r[28:25];
                // All kept opcodes end in 01
                if (op[1:0] == 2'b01) begin
                    op[1:0] = 2'b00;
                end
                return {op, r[31:20]};
            end
        endcase
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instr(input logic [15:0] instr);
        int waited;
        waited = 0;
        i_instr_valid = 1'b1;
        i_instr = instr;
        @(posedge clk);
        while (!o_instr_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!o_instr_ready) begin
            abort_on_timeout("o_instr_ready");
        end else begin
            execute_instr(instr);
            @(negedge clk);
            i_instr_valid = 1'b0;
        end
    endtask

    task automatic run_random(input int count);
        repeat (count) begin
            instr_rng = xorshift(instr_rng);
            // Idle gap on about one slot in four
            if (instr_rng[1:0] == 2'b00) begin
                repeat (instr_rng[3:2] + 1) @(negedge clk);
            end
            send_instr(random_instr());
        end
    endtask

    // Changed away from the falling edge where i_wb_ready is driven
    task automatic set_stall(input int pct);
        @(posedge clk);
        stall_pct = pct;
        @(negedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((expect_q.size() != 0 || o_wb_valid) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (expect_q.size() != 0 || o_wb_valid) begin
            abort_on_timeout("the pipeline to drain");
        end
    endtask

    always @(negedge clk) begin
        stall_rng = xorshift(stall_rng);
        i_wb_ready = (stall_rng % 100) >= stall_pct;
    end

    // Writeback monitor, cc is checked once the transfer edge has passed
    always @(posedge clk) begin
        logic [21:0] exp_wb;
        if (i_rst_n && o_wb_valid) begin
            if (!i_wb_ready) begin
                check("o_instr_ready during stall", o_instr_ready, 1'b0);
            end else if (expect_q.size() == 0) begin
                $display("Unexpected writeback to R%0d at %0t ns", o_wb_dest, $time);
                error_count++;
            end else begin
                exp_wb = expect_q.pop_front();
                check("o_wb_dest", o_wb_dest, exp_wb[21:19]);
                check("o_wb_data", o_wb_data, exp_wb[18:3]);
                wb_count++;
                @(negedge clk);
                check("o_cc", o_cc, exp_wb[2:0]);
            end
        end
    end

    initial begin
        i_rst_n = 1'b0;
        i_instr_valid = 1'b0;
        i_instr = 16'h0000;
        i_wb_ready = 1'b1;
        reset_model();
        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;
        check("o_wb_valid after reset", o_wb_valid, 1'b0);
        check("o_instr_ready after reset", o_instr_ready, 1'b1);
        check("o_cc after reset", o_cc, 3'b010);
        // ADD R0, R0, #0
        send_instr(16'h1020);
        run_random(400);
        set_stall(30);
        run_random(600);
        // Nearly every instruction now reads one of the last two results
        dep_mode = 1'b1;
        set_stall(0);
        run_random(300);
        set_stall(25);
        run_random(300);
        set_stall(0);
        drain();
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule : lc3b_core_tb

//--- src/lc3b_core.sv
`timescale 1ns/1ns

module lc3b_core (
    input  logic                 clk,
    input  logic                 i_rst_n,

    // Instruction stream
    input  logic                 i_instr_valid,
    input  lc3b_pkg::lc3b_word_t i_instr,
    output logic                 o_instr_ready,

    // Writeback stream
    output logic                 o_wb_valid,
    output lc3b_pkg::lc3b_reg_t  o_wb_dest,
    output lc3b_pkg::lc3b_word_t o_wb_data,
    output lc3b_pkg::lc3b_nzp_t  o_cc,
    input  logic                 i_wb_ready
);
    import lc3b_pkg::*;

    logic       wr_en;
    lc3b_reg_t  wr_dest;
    lc3b_word_t wr_data;

    lc3b_stage_if  stage_bus ();
    lc3b_result_if res_bus ();

    lc3b_decode decode_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .i_hold        (res_bus.hold),
        .i_wr_en       (wr_en),
        .i_wr_dest     (wr_dest),
        .i_wr_data     (wr_data),
        .stage         (stage_bus.src)
    );

    lc3b_execute execute_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .stage   (stage_bus.sink),
        .res     (res_bus.src)
    );

    lc3b_result result_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .res        (res_bus.sink),
        .i_wb_ready (i_wb_ready),
        .o_wb_valid (o_wb_valid),
        .o_wb_dest  (o_wb_dest),
        .o_wb_data  (o_wb_data),
        .o_cc       (o_cc),
        .o_wr_en    (wr_en),
        .o_wr_dest  (wr_dest),
        .o_wr_data  (wr_data)
    );

endmodule : lc3b_core

//--- src/lc3b_decode.sv
`timescale 1ns/1ns

module lc3b_decode (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_instr_valid,
    input  lc3b_pkg::lc3b_word_t i_instr,
    output logic                 o_instr_ready,
    input  logic                 i_hold,
    input  logic                 i_wr_en,
    input  lc3b_pkg::lc3b_reg_t  i_wr_dest,
    input  lc3b_pkg::lc3b_word_t i_wr_data,
    lc3b_stage_if.src            stage
);
    import lc3b_pkg::*;

    lc3b_opcode_t opcode;
    lc3b_reg_t    dest;
    lc3b_reg_t    src1;
    lc3b_reg_t    src2;
    lc3b_word_t   src1_data;
    lc3b_word_t   src2_data;
    lc3b_aluop_t  aluop;
    lc3b_word_t   operand_b;
    logic         b_is_reg;
    logic         write_en;
    logic         accept;

    assign o_instr_ready = ~i_hold;
    assign accept        = i_instr_valid & o_instr_ready;

    // Instruction fields
    assign opcode = lc3b_opcode_t'(i_instr[15:12]);
    assign dest   = i_instr[11:9];
    assign src1   = i_instr[8:6];
    assign src2   = i_instr[2:0];

    lc3b_regfile regfile_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_wr_en     (i_wr_en),
        .i_wr_dest   (i_wr_dest),
        .i_wr_data   (i_wr_data),
        .i_src1      (src1),
        .i_src2      (src2),
        .o_src1_data (src1_data),
        .o_src2_data (src2_data)
    );

    always_comb begin
        aluop     = alu_pass;
        operand_b = src2_data;
        b_is_reg  = 1'b0;
        write_en  = 1'b0;
        case (opcode)
            op_add, op_and: begin
                aluop    = (opcode == op_add) ? alu_add : alu_and;
                write_en = 1'b1;
                // Bit 5 selects imm5 over SR2
                if (i_instr[5]) begin
                    operand_b = {{11{i_instr[4]}}, i_instr[4:0]};
                end else begin
                    b_is_reg = 1'b1;
                end
            end
            op_not: begin
                aluop    = alu_not;
                write_en = 1'b1;
            end
            op_shf: begin
                operand_b = {12'h000, i_instr[3:0]};
                write_en  = 1'b1;
                // Bit 4 is direction, bit 5 arithmetic
                case (i_instr[5:4])
                    2'b01:   aluop = alu_srl;
                    2'b11:   aluop = alu_sra;
                    default: aluop = alu_sll;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            stage.valid    <= 1'b0;
            stage.write_en <= 1'b0;
        end else if (!i_hold) begin
            stage.valid    <= accept;
            stage.write_en <= write_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            stage.aluop     <= aluop;
            stage.dest      <= dest;
            stage.src1      <= src1;
            stage.src2      <= src2;
            stage.src1_data <= src1_data;
            stage.operand_b <= operand_b;
            stage.b_is_reg  <= b_is_reg;
        end
    end

endmodule : lc3b_decode

//--- src/lc3b_execute.sv
`timescale 1ns/1ns

module lc3b_execute (
    input  logic          clk,
    input  logic          i_rst_n,
    lc3b_stage_if.sink    stage,
    lc3b_result_if.src    res
);
    import lc3b_pkg::*;

    lc3b_word_t opa;
    lc3b_word_t opb;
    lc3b_word_t alu_out;
    logic       fwd_ok;

    // Result register holds a write one instruction ahead
    assign fwd_ok = res.valid & res.write_en;

    assign opa = (fwd_ok && (res.dest == stage.src1)) ? res.data : stage.src1_data;

    // Only a register operand can be stale, immediates pass through
    assign opb = (fwd_ok && stage.b_is_reg && (res.dest == stage.src2))
               ? res.data : stage.operand_b;

    always_comb begin
        case (stage.aluop)
            alu_add: alu_out = opa + opb;
            alu_and: alu_out = opa & opb;
            alu_not: alu_out = ~opa;
            alu_sll: alu_out = opa << opb[3:0];
            alu_srl: alu_out = opa >> opb[3:0];
            alu_sra: alu_out = $unsigned($signed(opa) >>> opb[3:0]);
            default: alu_out = opa;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            res.valid    <= 1'b0;
            res.write_en <= 1'b0;
        end else if (!res.hold) begin
            res.valid    <= stage.valid;
            res.write_en <= stage.write_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!res.hold) begin
            res.dest <= stage.dest;
            res.data <= alu_out;
        end
    end

endmodule : lc3b_execute

//--- src/lc3b_pkg.sv
package lc3b_pkg;

    // One machine word
    typedef logic [15:0] lc3b_word_t;

    // Index into the eight-entry register file
    typedef logic [2:0] lc3b_reg_t;

    // Kept opcodes, any other encoding retires as a bubble
    typedef enum logic [3:0] {
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_not = 4'b1001,
        op_shf = 4'b1101
    } lc3b_opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass
    } lc3b_aluop_t;

    // Bit 2 is n, bit 1 is z, bit 0 is p
    typedef logic [2:0] lc3b_nzp_t;

    localparam lc3b_nzp_t CC_RESET = 3'b010;

endpackage : lc3b_pkg

//--- src/lc3b_regfile.sv
`timescale 1ns/1ns

module lc3b_regfile (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_wr_en,
    input  lc3b_pkg::lc3b_reg_t  i_wr_dest,
    input  lc3b_pkg::lc3b_word_t i_wr_data,
    input  lc3b_pkg::lc3b_reg_t  i_src1,
    input  lc3b_pkg::lc3b_reg_t  i_src2,
    output lc3b_pkg::lc3b_word_t o_src1_data,
    output lc3b_pkg::lc3b_word_t o_src2_data
);
    import lc3b_pkg::*;

    lc3b_word_t regs [8];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_dest] <= i_wr_data;
        end
    end

    // Write-through so a same-cycle writeback is seen by decode
    always_comb begin
        if (i_wr_en && (i_wr_dest == i_src1)) begin
            o_src1_data = i_wr_data;
        end else begin
            o_src1_data = regs[i_src1];
        end

        if (i_wr_en && (i_wr_dest == i_src2)) begin
            o_src2_data = i_wr_data;
        end else begin
            o_src2_data = regs[i_src2];
        end
    end

endmodule : lc3b_regfile

//--- src/lc3b_result.sv
`timescale 1ns/1ns

module lc3b_result (
    input  logic                 clk,
    input  logic                 i_rst_n,
    lc3b_result_if.sink          res,
    input  logic                 i_wb_ready,
    output logic                 o_wb_valid,
    output lc3b_pkg::lc3b_reg_t  o_wb_dest,
    output lc3b_pkg::lc3b_word_t o_wb_data,
    output lc3b_pkg::lc3b_nzp_t  o_cc,
    output logic                 o_wr_en,
    output lc3b_pkg::lc3b_reg_t  o_wr_dest,
    output lc3b_pkg::lc3b_word_t o_wr_data
);
    import lc3b_pkg::*;

    lc3b_nzp_t cc_q;
    lc3b_nzp_t cc_next;
    logic      wb_fire;

    // Bubbles stay in the result register but are never presented
    assign o_wb_valid = res.valid & res.write_en;
    assign o_wb_dest  = res.dest;
    assign o_wb_data  = res.data;

    assign res.hold = o_wb_valid & ~i_wb_ready;
    assign wb_fire  = o_wb_valid & i_wb_ready;

    // Regfile write on the completing edge
    assign o_wr_en   = wb_fire;
    assign o_wr_dest = res.dest;
    assign o_wr_data = res.data;

    always_comb begin
        if (res.data[15]) begin
            cc_next = 3'b100;
        end else if (res.data == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cc_q <= CC_RESET;
        end else if (wb_fire) begin
            cc_q <= cc_next;
        end
    end

    assign o_cc = cc_q;

endmodule : lc3b_result

//--- src/lc3b_result_if.sv
`timescale 1ns/1ns

interface lc3b_result_if;
    import lc3b_pkg::*;

    logic       valid;
    lc3b_reg_t  dest;
    lc3b_word_t data;
    logic       write_en;

    // Writeback stalled, every pipeline register keeps its contents
    logic       hold;

    // Execute side, also reads its own result register for forwarding
    modport src (
        output valid, dest, data, write_en,
        input  hold
    );

    modport sink (
        input  valid, dest, data, write_en,
        output hold
    );

endinterface : lc3b_result_if

//--- src/lc3b_stage_if.sv
`timescale 1ns/1ns

interface lc3b_stage_if;
    import lc3b_pkg::*;

    logic        valid;
    lc3b_aluop_t aluop;
    lc3b_reg_t   dest;
    lc3b_reg_t   src1;
    lc3b_reg_t   src2;
    lc3b_word_t  src1_data;
    // Immediate already substituted where the instruction has one
    lc3b_word_t  operand_b;
    logic        b_is_reg;
    logic        write_en;

    modport src (
        output valid, aluop, dest, src1, src2,
        output src1_data, operand_b, b_is_reg, write_en
    );

    modport sink (
        input valid, aluop, dest, src1, src2,
        input src1_data, operand_b, b_is_reg, write_en
    );

endinterface : lc3b_stage_if
